// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_rider_status
FILELIST ?= all.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(BUILD) $(LOG)

// File: all.f
+incdir+design
design/rider_status_pkg.sv
design/soft_error_monitor.sv
design/status_reg_block.sv
design/status_read_port.sv
design/rider_status_top.sv
dv/clk_gen.sv
dv/tb_rider_status.sv

// File: design/rider_consts.svh
`ifndef RIDER_CONSTS_SVH
`define RIDER_CONSTS_SVH

// Firmware revision, packed into status word 0 as major.minor.patch
`define MAJOR_REV 8'd3
`define MINOR_REV 8'd1
`define PATCH_REV 8'd4

// Register map size
`define NUM_STATUS_REGS 19

// Enough to address all status words, upper codes read as zero
`define STATUS_ADDR_W 5

// Soft-error counter width, one full status word per count
`define CNT_W 32

`endif

// File: design/rider_status_pkg.sv
`include "rider_consts.svh"

package rider_status_pkg;

  // One status word on the read port
  typedef logic [31:0] status_word_t;

  // Whole register map, word 0 in the low slice
  typedef logic [`NUM_STATUS_REGS-1:0][31:0] status_words_t;

  // Word 1 hard-error flags, MSB first so bit 0 is pll_unlock
  typedef struct packed {
    logic trig_type_from_cm;  // Bit 7
    logic trig_type_from_tt;
    logic trig_num_from_cm;
    logic trig_num_from_tt;
    logic data_corrupt;       // Bit 3, set by soft-error monitor
    logic trig_rate;
    logic unknown_ttc;        // Bit 1, set by soft-error monitor
    logic pll_unlock;         // Bit 0
  } hard_err_t;

  // External clock and clock synthesizer status
  typedef struct packed {
    logic daq_clk_sel;
    logic daq_clk_en;
    logic adcclk_clkin0_stat;
    logic adcclk_clkin1_stat;
    logic adcclk_stat_ld;  // Synthesizer lock detect
    logic adcclk_stat;
  } clk_stat_t;

  // DAQ link and TTC/TTS
  typedef struct packed {
    logic       daq_almost_full;
    logic       daq_ready;
    logic [3:0] tts_state;
    logic [5:0] ttc_chan_b_info;  // Channel B broadcast info
    logic       ttc_ready;
  } link_stat_t;

  // Controller FSM states, one-hot or encoded as each FSM keeps them
  typedef struct packed {
    logic [30:0] cm_state;   // Channel manager
    logic [3:0]  ttr_state;  // Trigger receiver
    logic [3:0]  cac_state;  // Channel acquisition controller
    logic [6:0]  tp_state;   // Trigger processor
  } fsm_state_t;

  // Acquisition setup
  typedef struct packed {
    logic [4:0] acq_readout_pause;
    logic [1:0] fill_type;
    logic [4:0] chan_en;         // One bit per digitizer channel
    logic       endianness_sel;
  } acq_stat_t;

  // Trigger information
  typedef struct packed {
    logic        trig_fifo_full;
    logic        acq_fifo_full;
    logic [3:0]  trig_delay;
    logic [7:0]  trig_settings;
    logic [23:0] trig_num;
    logic [43:0] trig_timestamp;  // Split over words 11 and 12
  } trig_stat_t;

  // Soft-error thresholds or counts, data_corrupt in the top slice
  typedef struct packed {
    logic [`CNT_W-1:0] data_corrupt;
    logic [`CNT_W-1:0] unknown_ttc;
    logic [`CNT_W-1:0] ddr3_overflow;
  } soft_err_t;

  // Same bits as soft_err_t, indexable by event kind
  // Index 2 data_corrupt, 1 unknown_ttc, 0 ddr3_overflow
  typedef logic [2:0][`CNT_W-1:0] soft_err_vec_t;

endpackage

// File: design/rider_status_top.sv
`timescale 1ns/1ns
`include "rider_consts.svh"

module rider_status_top (
  input  logic                          clk,
  input  logic                          rst_n,
  // Soft-error event strobes
  input  logic                          ev_data_corrupt,
  input  logic                          ev_unknown_ttc,
  input  logic                          ev_ddr3_overflow,
  input  logic                          cnt_clear,
  input  rider_status_pkg::soft_err_t   thres,
  // Outside hard errors, MSB first
  // trig_type_from_cm, trig_type_from_tt, trig_num_from_cm, trig_num_from_tt,
  // trig_rate, pll_unlock
  input  logic [5:0]                    ext_err,
  input  logic [4:0]                    chan_error_rc,
  input  logic                          prog_chan_done,
  input  rider_status_pkg::clk_stat_t   clk_stat,
  input  rider_status_pkg::link_stat_t  link_stat,
  input  rider_status_pkg::fsm_state_t  fsm_state,
  input  rider_status_pkg::acq_stat_t   acq_stat,
  input  rider_status_pkg::trig_stat_t  trig_stat,
  // Register read port
  input  logic                          rd_strobe,
  input  logic [`STATUS_ADDR_W-1:0]     rd_addr,
  output logic [31:0]                   rdata,
  output logic                          rd_valid
);
  import rider_status_pkg::*;

  soft_err_t     counts;
  logic          err_data_corrupt;
  logic          err_unknown_ttc;
  logic          ddr3_overflow_warning;  // Monitor output, not in the register map
  hard_err_t     hard_err;
  status_words_t words;

  // Monitor flags slot into bits 3 and 1 of word 1
  assign hard_err = {ext_err[5:2], err_data_corrupt, ext_err[1], err_unknown_ttc,
                     ext_err[0]};

  soft_error_monitor i_monitor (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .ev_data_corrupt       (ev_data_corrupt),
    .ev_unknown_ttc        (ev_unknown_ttc),
    .ev_ddr3_overflow      (ev_ddr3_overflow),
    .cnt_clear             (cnt_clear),
    .thres                 (thres),
    .counts                (counts),
    .err_data_corrupt      (err_data_corrupt),
    .err_unknown_ttc       (err_unknown_ttc),
    .ddr3_overflow_warning (ddr3_overflow_warning)
  );

  status_reg_block i_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .prog_chan_done (prog_chan_done),
    .hard_err       (hard_err),
    .chan_error_rc  (chan_error_rc),
    .clk_stat       (clk_stat),
    .link_stat      (link_stat),
    .fsm_state      (fsm_state),
    .acq_stat       (acq_stat),
    .trig_stat      (trig_stat),
    .thres          (thres),
    .counts         (counts),
    .words          (words)
  );

  status_read_port i_rd_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .words     (words),
    .rd_strobe (rd_strobe),
    .rd_addr   (rd_addr),
    .rdata     (rdata),
    .rd_valid  (rd_valid)
  );

endmodule

// File: design/soft_error_monitor.sv
`timescale 1ns/1ns
`include "rider_consts.svh"

module soft_error_monitor (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ev_data_corrupt,   // One-cycle event strobes
  input  logic                      ev_unknown_ttc,
  input  logic                      ev_ddr3_overflow,
  input  logic                      cnt_clear,         // Zeroes counts and flags
  input  rider_status_pkg::soft_err_t thres,           // Zero disables a flag
  output rider_status_pkg::soft_err_t counts,
  output logic                      err_data_corrupt,
  output logic                      err_unknown_ttc,
  output logic                      ddr3_overflow_warning
);
  import rider_status_pkg::*;

  soft_err_vec_t cnt_q;     // Live counters
  soft_err_vec_t cnt_nxt;
  soft_err_vec_t thr;       // Thresholds as an array
  logic [2:0]    ev;
  logic [2:0]    flag_q;    // Sticky threshold flags
  logic [2:0]    flag_nxt;

  // Same slice order as the struct, data_corrupt on top
  assign ev  = {ev_data_corrupt, ev_unknown_ttc, ev_ddr3_overflow};
  assign thr = thres;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      // Hold at all ones instead of wrapping
      if (ev[i] && (cnt_q[i] != '1)) begin
        cnt_nxt[i] = cnt_q[i] + `CNT_W'(1);
      end else begin
        cnt_nxt[i] = cnt_q[i];
      end
      // Compare against next count so flag rises with the count
      flag_nxt[i] = flag_q[i] | ((thr[i] != '0) && (cnt_nxt[i] >= thr[i]));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || cnt_clear) begin  // Clear beats a same-cycle event
      cnt_q  <= '0;
      flag_q <= '0;
    end else begin
      cnt_q  <= cnt_nxt;
      flag_q <= flag_nxt;
    end
  end

  assign counts                = cnt_q;
  assign err_data_corrupt      = flag_q[2];
  assign err_unknown_ttc       = flag_q[1];
  assign ddr3_overflow_warning = flag_q[0];

  for (genvar g = 0; g < 3; g++) begin : g_chk
    // Only a clear can take a counter down
    a_cnt_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(rst_n) && !$past(cnt_clear)) |-> (cnt_q[g] >= $past(cnt_q[g])))
      else $error("soft-error counter %0d went down without clear", g);

    // Flags are sticky until cleared
    a_flag_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(rst_n) && $past(flag_q[g]) && !$past(cnt_clear)) |-> flag_q[g])
      else $error("soft-error flag %0d dropped without clear", g);
  end

endmodule

// File: design/status_read_port.sv
`timescale 1ns/1ns
`include "rider_consts.svh"

module status_read_port (
  input  logic                            clk,
  input  logic                            rst_n,
  input  rider_status_pkg::status_words_t words,
  input  logic                            rd_strobe,  // One read per strobe
  input  logic [`STATUS_ADDR_W-1:0]       rd_addr,
  output logic [31:0]                     rdata,      // Held between reads
  output logic                            rd_valid
);
  import rider_status_pkg::*;

  status_word_t sel_word;
  logic         addr_ok;

  // Upper address codes have no word behind them
  assign addr_ok  = rd_addr < `STATUS_ADDR_W'(`NUM_STATUS_REGS);
  assign sel_word = addr_ok ? words[rd_addr] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata    <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_strobe;  // Valid for exactly one cycle per strobe
      if (rd_strobe) begin
        rdata <= sel_word;
      end
    end
  end

  // Valid pulse tracks strobe with one cycle lag, no more, no less
  a_valid_follows_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (rd_valid == $past(rd_strobe)))
    else $error("rd_valid out of step with rd_strobe");

endmodule

// File: design/status_reg_block.sv
`timescale 1ns/1ns
`include "rider_consts.svh"

module status_reg_block (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          prog_chan_done,  // Channel FPGAs programmed
  input  rider_status_pkg::hard_err_t   hard_err,
  input  logic [4:0]                    chan_error_rc,
  input  rider_status_pkg::clk_stat_t   clk_stat,
  input  rider_status_pkg::link_stat_t  link_stat,
  input  rider_status_pkg::fsm_state_t  fsm_state,
  input  rider_status_pkg::acq_stat_t   acq_stat,
  input  rider_status_pkg::trig_stat_t  trig_stat,
  input  rider_status_pkg::soft_err_t   thres,
  input  rider_status_pkg::soft_err_t   counts,
  output rider_status_pkg::status_words_t words   // Registered snapshot
);
  import rider_status_pkg::*;

  // Significant width of each word, anything above must read zero
  localparam int unsigned USED_W [`NUM_STATUS_REGS] = '{
    31, 13, 2, 4, 2, 11, 31, 15, 13, 14, 24, 32, 12, 32, 32, 32, 32, 32, 32
  };

  status_words_t words_d;

  always_comb begin
    words_d = '0;
    // Firmware revision, bit 30 reports channel programming
    words_d[0]  = {1'b0, prog_chan_done, 6'd0, `MAJOR_REV, `MINOR_REV, `PATCH_REV};
    words_d[1]  = {19'd0, chan_error_rc, hard_err};  // Errors and warnings
    // External clock
    words_d[2]  = {30'd0, clk_stat.daq_clk_sel, clk_stat.daq_clk_en};
    // Clock synthesizer
    words_d[3]  = {28'd0, clk_stat.adcclk_clkin1_stat, clk_stat.adcclk_clkin0_stat,
                   clk_stat.adcclk_stat_ld, clk_stat.adcclk_stat};
    words_d[4]  = {30'd0, link_stat.daq_almost_full, link_stat.daq_ready};  // DAQ link
    // TTC/TTS
    words_d[5]  = {21'd0, link_stat.tts_state, link_stat.ttc_chan_b_info,
                   link_stat.ttc_ready};
    words_d[6]  = {1'b0, fsm_state.cm_state};  // FSM state 0
    // FSM state 1
    words_d[7]  = {17'd0, fsm_state.tp_state, fsm_state.cac_state, fsm_state.ttr_state};
    // Acquisition
    words_d[8]  = {19'd0, acq_stat.endianness_sel, acq_stat.acq_readout_pause,
                   acq_stat.fill_type, acq_stat.chan_en};
    // Trigger information
    words_d[9]  = {18'd0, trig_stat.trig_settings, trig_stat.acq_fifo_full,
                   trig_stat.trig_fifo_full, trig_stat.trig_delay};
    words_d[10] = {8'd0, trig_stat.trig_num};
    words_d[11] = trig_stat.trig_timestamp[31:0];           // Timestamp LSBs
    words_d[12] = {20'd0, trig_stat.trig_timestamp[43:32]}; // Timestamp MSBs
    // Threshold and count pairs
    words_d[13] = thres.data_corrupt;
    words_d[14] = counts.data_corrupt;  // From the monitor, not a checksum counter
    words_d[15] = thres.unknown_ttc;
    words_d[16] = counts.unknown_ttc;
    words_d[17] = thres.ddr3_overflow;
    words_d[18] = counts.ddr3_overflow;
  end

  // One cycle snapshot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      words <= '0;
    end else begin
      words <= words_d;
    end
  end

  for (genvar g = 0; g < `NUM_STATUS_REGS; g++) begin : g_chk
    // Padding of each word stays clear whatever the inputs
    a_pad_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (words[g] >> USED_W[g]) == '0)
      else $error("status word %0d has bits set above bit %0d", g, USED_W[g] - 1);
  end

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
  output logic clk,
  output logic rst_n
);
  localparam int HALF_PERIOD = 4;  // 8 ns clock
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Synchronous reset, released right on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: dv/tb_rider_status.sv
`timescale 1ns/1ns
`include "rider_consts.svh"

module tb_rider_status;
  import rider_status_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int EVENT_ROUNDS  = 6;
  localparam int EVENT_CYCLES  = 150;
  localparam int STATUS_ROUNDS = 8;
  localparam int SETTLE        = 4;   // Event to rdata takes four cycles
  localparam int SWEEP_MAX     = 70;  // 32 reads, worst-case gaps, tail
  localparam int RUN_CYCLES    = 20 + 2 * SWEEP_MAX + STATUS_ROUNDS * (4 + SWEEP_MAX)
                                 + EVENT_ROUNDS * (EVENT_CYCLES + 2 * SETTLE + SWEEP_MAX);
  localparam int MARGIN        = 200;
  localparam int DC = 0;  // Model index per event kind
  localparam int UT = 1;
  localparam int OV = 2;

  logic clk;
  logic rst_n;
  logic ev_data_corrupt;
  logic ev_unknown_ttc;
  logic ev_ddr3_overflow;
  logic cnt_clear;
  soft_err_t thres;
  logic [5:0] ext_err;
  logic [4:0] chan_error_rc;
  logic prog_chan_done;
  clk_stat_t clk_stat;
  link_stat_t link_stat;
  fsm_state_t fsm_state;
  acq_stat_t acq_stat;
  trig_stat_t trig_stat;
  logic rd_strobe;
  logic [`STATUS_ADDR_W-1:0] rd_addr;
  logic [31:0] rdata;
  logic rd_valid;

  logic [31:0] ref_cnt [3];  // Reference counters
  logic [2:0]  ref_flag;     // Reference sticky flags
  logic [31:0] read_exp;     // Expected word for the strobe in flight
  logic [31:0] read_exp_d;   // Lines up with rd_valid
  int          read_addr;
  int          read_addr_d;
  int          errors = 0;
  int          reads = 0;
  logic [31:0] lcg_state = 32'he17d_6ce5;

  clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

  rider_status_top i_dut (
    .clk(clk), .rst_n(rst_n),
    .ev_data_corrupt(ev_data_corrupt), .ev_unknown_ttc(ev_unknown_ttc),
    .ev_ddr3_overflow(ev_ddr3_overflow), .cnt_clear(cnt_clear), .thres(thres),
    .ext_err(ext_err), .chan_error_rc(chan_error_rc), .prog_chan_done(prog_chan_done),
    .clk_stat(clk_stat), .link_stat(link_stat), .fsm_state(fsm_state),
    .acq_stat(acq_stat), .trig_stat(trig_stat),
    .rd_strobe(rd_strobe), .rd_addr(rd_addr), .rdata(rdata), .rd_valid(rd_valid)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return lcg_state;
  endfunction

  function automatic logic [31:0] threshold_of(input int k);
    case (k)
      DC:      return thres.data_corrupt;
      UT:      return thres.unknown_ttc;
      default: return thres.ddr3_overflow;
    endcase
  endfunction

  function automatic logic [31:0] pick_threshold();
    logic [31:0] r;
    r = next_rand();
    if (r[9:8] == 2'd0) return '0;  // Disabled flag about a quarter of the time
    return {25'd0, r[6:0]};        // Small, so some trains reach it
  endfunction

  // Register map as the board documents it
  function automatic logic [31:0] expected_word(input int addr);
    logic [31:0] w;
    w = '0;
    case (addr)
      0: begin
        w[30]    = prog_chan_done;
        w[23:16] = `MAJOR_REV;
        w[15:8]  = `MINOR_REV;
        w[7:0]   = `PATCH_REV;
      end
      1: begin
        w[0]    = ext_err[0];    // pll_unlock
        w[1]    = ref_flag[UT];
        w[2]    = ext_err[1];    // trig_rate
        w[3]    = ref_flag[DC];
        w[7:4]  = ext_err[5:2];
        w[12:8] = chan_error_rc;
      end
      2: begin
        w[0] = clk_stat.daq_clk_en;
        w[1] = clk_stat.daq_clk_sel;
      end
      3: begin
        w[0] = clk_stat.adcclk_stat;
        w[1] = clk_stat.adcclk_stat_ld;
        w[2] = clk_stat.adcclk_clkin0_stat;
        w[3] = clk_stat.adcclk_clkin1_stat;
      end
      4: begin
        w[0] = link_stat.daq_ready;
        w[1] = link_stat.daq_almost_full;
      end
      5: begin
        w[0]    = link_stat.ttc_ready;
        w[6:1]  = link_stat.ttc_chan_b_info;
        w[10:7] = link_stat.tts_state;
      end
      6: w[30:0] = fsm_state.cm_state;
      7: begin
        w[3:0]  = fsm_state.ttr_state;
        w[7:4]  = fsm_state.cac_state;
        w[14:8] = fsm_state.tp_state;
      end
      8: begin
        w[4:0]  = acq_stat.chan_en;
        w[6:5]  = acq_stat.fill_type;
        w[11:7] = acq_stat.acq_readout_pause;
        w[12]   = acq_stat.endianness_sel;
      end
      9: begin
        w[3:0]  = trig_stat.trig_delay;
        w[4]    = trig_stat.trig_fifo_full;
        w[5]    = trig_stat.acq_fifo_full;
        w[13:6] = trig_stat.trig_settings;
      end
      10: w[23:0] = trig_stat.trig_num;
      11: w = trig_stat.trig_timestamp[31:0];
      12: w[11:0] = trig_stat.trig_timestamp[43:32];
      13: w = thres.data_corrupt;
      14: w = ref_cnt[DC];
      15: w = thres.unknown_ttc;
      16: w = ref_cnt[UT];
      17: w = thres.ddr3_overflow;
      18: w = ref_cnt[OV];
      default: w = '0;  // Nothing mapped from 19 up
    endcase
    return w;
  endfunction

  // Reference counters, saturating, clear has priority
  always @(posedge clk) begin : ref_model
    logic [2:0]  ev;
    logic [31:0] nxt;
    ev = {ev_ddr3_overflow, ev_unknown_ttc, ev_data_corrupt};
    if (!rst_n || cnt_clear) begin
      for (int k = 0; k < 3; k++) ref_cnt[k] <= '0;
      ref_flag <= '0;
    end else begin
      for (int k = 0; k < 3; k++) begin
        nxt = ref_cnt[k];
        if (ev[k] && ref_cnt[k] != 32'hffff_ffff) nxt = ref_cnt[k] + 32'd1;
        ref_cnt[k] <= nxt;
        if (threshold_of(k) != 0 && nxt >= threshold_of(k)) ref_flag[k] <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    read_exp_d  <= read_exp;
    read_addr_d <= read_addr;
    if (rd_valid) reads++;
  end

  task automatic note_mismatch(input string what);
    errors++;
    $display("mismatch at %0t ns: %s", $time, what);
  endtask

  a_valid_timing: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (rd_valid == $past(rd_strobe)))
    else note_mismatch("rd_valid out of step with rd_strobe");

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid |-> (rdata == read_exp_d))
    else note_mismatch($sformatf("word %0d read %h, expected %h",
                                 read_addr_d, rdata, read_exp_d));

  // Read data only moves with a valid
  a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !rd_valid |-> $stable(rdata))
    else note_mismatch("rdata changed without a read strobe");

  a_overflow_warning: assert property (@(posedge clk) disable iff (!rst_n)
    i_dut.ddr3_overflow_warning == ref_flag[OV])
    else note_mismatch($sformatf("ddr3_overflow_warning %0b, expected %0b",
                                 i_dut.ddr3_overflow_warning, ref_flag[OV]));

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic read_word(input int addr);
    @(posedge clk);
    rd_strobe <= 1'b1;
    rd_addr   <= `STATUS_ADDR_W'(addr);
    read_exp  <= expected_word(addr);
    read_addr <= addr;
  endtask

  // Every address once, optionally with idle cycles between strobes
  task automatic sweep_reads(input bit gaps);
    logic [31:0] r;
    for (int a = 0; a < (1 << `STATUS_ADDR_W); a++) begin
      read_word(a);
      r = next_rand();
      if (gaps && r[0]) begin
        @(posedge clk);
        rd_strobe <= 1'b0;
      end
    end
    @(posedge clk);
    rd_strobe <= 1'b0;
    idle(2);  // Last valid lands
  endtask

  task automatic set_thresholds();
    @(posedge clk);
    thres <= {pick_threshold(), pick_threshold(), pick_threshold()};
    idle(SETTLE);
  endtask

  task automatic event_train(input int cycles);
    logic [31:0] r;
    for (int c = 0; c < cycles; c++) begin
      r = next_rand();
      @(posedge clk);
      ev_data_corrupt  <= (r[1:0] == 2'd0);
      ev_unknown_ttc   <= (r[3:2] == 2'd0);
      ev_ddr3_overflow <= (r[5:4] == 2'd0);
      cnt_clear        <= (r[11:6] == 6'd0);  // Rare, sometimes with an event
    end
    @(posedge clk);
    {ev_data_corrupt, ev_unknown_ttc, ev_ddr3_overflow, cnt_clear} <= '0;
  endtask

  task automatic randomize_status();
    logic [127:0] r;
    logic [127:0] s;
    r = {next_rand(), next_rand(), next_rand(), next_rand()};
    s = {next_rand(), next_rand(), next_rand(), next_rand()};
    @(posedge clk);
    trig_stat      <= r[81:0];
    fsm_state      <= r[127:82];
    clk_stat       <= s[5:0];
    link_stat      <= s[18:6];
    acq_stat       <= s[31:19];
    ext_err        <= s[37:32];
    chan_error_rc  <= s[42:38];
    prog_chan_done <= s[43];
    thres          <= s[127:32];  // Full-width thresholds, flags stay sticky
  endtask

  initial begin
    #((RUN_CYCLES + MARGIN) * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", RUN_CYCLES + MARGIN);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    {ev_data_corrupt, ev_unknown_ttc, ev_ddr3_overflow, cnt_clear} <= '0;
    thres <= '0;
    ext_err <= '0;
    chan_error_rc <= '0;
    prog_chan_done <= 1'b0;
    clk_stat <= '0;
    link_stat <= '0;
    fsm_state <= '0;
    acq_stat <= '0;
    trig_stat <= '0;
    rd_strobe <= 1'b0;
    rd_addr <= '0;
    read_exp <= '0;
    read_addr <= 0;
    wait (rst_n === 1'b1);
    idle(2);
    sweep_reads(1'b0);  // Reset values, back-to-back strobes
    for (int n = 0; n < EVENT_ROUNDS; n++) begin
      set_thresholds();
      event_train(EVENT_CYCLES);
      idle(SETTLE);
      sweep_reads(n[0]);
    end
    // Clear together with all three events
    @(posedge clk);
    thres <= {32'd1, 32'd1, 32'd1};
    {ev_data_corrupt, ev_unknown_ttc, ev_ddr3_overflow} <= 3'b111;
    idle(2);
    cnt_clear <= 1'b1;
    @(posedge clk);
    {ev_data_corrupt, ev_unknown_ttc, ev_ddr3_overflow, cnt_clear} <= '0;
    idle(SETTLE);
    sweep_reads(1'b0);
    for (int n = 0; n < STATUS_ROUNDS; n++) begin
      randomize_status();
      idle(1);  // Held two cycles before the first strobe
      sweep_reads(1'b1);
    end
    $display("checks done, %0d reads, %0d errors", reads, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
